/* project.f */
design/merge_pkg.sv
design/srl_queue.sv
design/rr_arbiter.sv
design/bus_req_ack.sv
design/merge_top.sv
bench/merge_asserts.sv
bench/merge_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
TOP=merge_tb

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module "$TOP" -Mdir "$OBJ_DIR" -o "$TOP" -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its verdict into the log
if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "no verdict found in $LOG"
  exit 1
fi
exit 0

/* bench/merge_tb.sv */
module merge_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import merge_pkg::*;

  localparam int DATA_W     = 32;
  localparam int DEPTH_LOG2 = 4;
  localparam int N_CH       = 4;
  localparam int WAIT_LIMIT = 2000;   // cycles allowed for any single wait
  localparam int RAND_CYCLES = 80;

  logic                        i_clk = 1'b0;
  logic                        i_rst_n;
  logic [N_CH-1:0]             i_wr;
  logic [N_CH-1:0][DATA_W-1:0] i_wr_data;
  logic                        i_ack;
  logic [N_CH-1:0]             o_full;
  logic [N_CH-1:0]             o_empty;
  logic [N_CH-1:0]             o_overrun;
  logic [N_CH-1:0]             o_underrun;
  logic                        o_req;
  logic [DATA_W-1:0]           o_data;
  ch_idx_t                     o_ch;

  integer seed = 42;
  logic   ack_en;                     // consumer answers only when set
  int     wr_seq  [N_CH] = '{default: 0};   // words accepted per channel
  int     exp_seq [N_CH] = '{default: 0};   // next sequence the checker expects
  int     ch_log  [$];                // channel of every completed transfer
  int     xfer_cnt = 0;
  int     n_mismatch = 0;
  int     n_other = 0;
  logic   prev_req = 1'b0;
  logic   prev_ack = 1'b0;

  always #5 i_clk = ~i_clk;

  merge_top #(
    .DATA_W     (DATA_W),
    .DEPTH_LOG2 (DEPTH_LOG2),
    .N_CH       (N_CH)
  ) UUT (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr       (i_wr),
    .i_wr_data  (i_wr_data),
    .i_ack      (i_ack),
    .o_full     (o_full),
    .o_empty    (o_empty),
    .o_overrun  (o_overrun),
    .o_underrun (o_underrun),
    .o_req      (o_req),
    .o_data     (o_data),
    .o_ch       (o_ch)
  );

  // word a producer writes for a given channel and sequence number
  function automatic logic [31:0] expected_word(input int ch, input int seq);
    logic [31:0] mix;
    mix = (32'(ch) << 28) ^ (32'(seq) * 32'h0001_0003) ^ 32'h00C3_5A00;
    return mix;
  endfunction

  function automatic int total_written();
    int sum;
    sum = 0;
    for (int c = 0; c < N_CH; c++) begin
      sum += wr_seq[c];
    end
    return sum;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      n_mismatch++;
    end
  endtask

  task automatic end_run();
    $display("transfers %0d, mismatches %0d, other errors %0d",
             xfer_cnt, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // one producer cycle that skips full queues
  task automatic write_cycle(input logic [N_CH-1:0] mask);
    @(posedge i_clk);
    #1;
    i_wr = '0;
    for (int c = 0; c < N_CH; c++) begin
      if (mask[c] && !o_full[c]) begin
        i_wr[c]      = 1'b1;
        i_wr_data[c] = expected_word(c, wr_seq[c]);
        wr_seq[c]++;
      end
    end
  endtask

  task automatic wait_transfers(input int n);
    int cycles;
    cycles = 0;
    while (xfer_cnt < n && cycles < WAIT_LIMIT) begin
      @(posedge i_clk);
      #1;
      cycles++;
    end
    if (xfer_cnt < n) begin
      $display("timeout at %0t: only %0d of %0d transfers completed", $time, xfer_cnt, n);
      n_other++;
    end
  endtask

  task automatic wait_req();
    int cycles;
    cycles = 0;
    while (!o_req && cycles < WAIT_LIMIT) begin
      @(posedge i_clk);
      #1;
      cycles++;
    end
    if (!o_req) begin
      $display("timeout at %0t: o_req never rose", $time);
      n_other++;
    end
  endtask

  // bus quiet and every queue drained
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while ((o_req || i_ack || o_empty != '1) && cycles < WAIT_LIMIT) begin
      @(posedge i_clk);
      #1;
      cycles++;
    end
    if (o_req || i_ack || o_empty != '1) begin
      $display("timeout at %0t: output bus or queues did not go idle", $time);
      n_other++;
    end
  endtask

  // consumer that acks after a random number of cycles
  initial begin : consumer
    int dly;
    dly   = 0;
    i_ack = 1'b0;
    forever begin
      @(posedge i_clk);
      #1;
      if (i_ack) begin
        if (!o_req) begin
          i_ack = 1'b0;  // request released so the four phases close
        end
      end else if (o_req && ack_en) begin
        if (dly == 0) begin
          i_ack = 1'b1;
          dly   = $unsigned($random(seed)) % 4;
        end else begin
          dly--;
        end
      end
    end
  end

  // compares every completed transfer and watches the handshake order
  always @(negedge i_clk) begin
    int ch;
    if (i_rst_n) begin
      if (o_req && !prev_req && prev_ack) begin
        $display("at %0t o_req rose while i_ack was still high", $time);
        n_other++;
      end
      if (!o_req && prev_req && !prev_ack) begin
        $display("at %0t o_req fell before i_ack was seen high", $time);
        n_other++;
      end
      if (o_req && i_ack) begin
        ch = int'(o_ch);
        if (ch >= N_CH) begin
          $display("at %0t transfer carries channel %0d, which does not exist", $time, ch);
          n_other++;
        end else begin
          if (o_data !== expected_word(ch, exp_seq[ch])) begin
            $display("MISMATCH at %0t: ch %0d seq %0d data %h, expected %h", $time, ch,
                     exp_seq[ch], o_data, expected_word(ch, exp_seq[ch]));
            n_mismatch++;
          end
          exp_seq[ch]++;
        end
        ch_log.push_back(ch);
        xfer_cnt++;
      end
    end
    prev_req = o_req;
    prev_ack = i_ack;
  end

  initial begin
    int base;
    int first;
    int n_ch2;
    logic [31:0] rnd;
    i_rst_n   = 1'b0;
    i_wr      = '0;
    i_wr_data = '0;
    ack_en    = 1'b1;
    repeat (3) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;

    // values straight out of reset
    check_value("o_req after reset", o_req, 1'b0);
    check_value("o_full after reset", o_full, '0);
    check_value("o_overrun after reset", o_overrun, '0);
    check_value("o_underrun after reset", o_underrun, '0);
    check_value("o_empty after reset", o_empty, {N_CH{1'b1}});

    // ten words on one channel with random ack delays
    for (int i = 0; i < 10; i++) begin
      write_cycle(4'b1000);
    end
    write_cycle('0);
    wait_transfers(10);
    for (int i = 0; i < 10; i++) begin
      check_value("channel of single-channel transfer", ch_log[i], 3);
    end

    // round robin with all queues loaded while the first transfer waits
    wait_idle();
    ack_en = 1'b0;
    for (int i = 0; i < 4; i++) begin
      write_cycle(4'b1111);
    end
    write_cycle('0);
    wait_req();
    base   = xfer_cnt;
    first  = 0;  // channel 3 was served last in the single-channel run
    ack_en = 1'b1;
    wait_transfers(base + 16);
    for (int i = 0; i < 16; i++) begin
      check_value("round-robin channel", ch_log[base+i], (first + i) % N_CH);
    end

    // channel 2 filled past its depth under back-pressure
    wait_idle();
    ack_en = 1'b0;
    base   = xfer_cnt;
    write_cycle(4'b0010);  // occupies the output stage
    write_cycle('0);
    wait_req();
    for (int i = 0; i < 16; i++) begin
      write_cycle(4'b0100);
      check_value("o_full[2] while filling", o_full[2], 1'b0);
    end
    write_cycle('0);
    check_value("o_full[2] with 16 words held", o_full[2], 1'b1);
    check_value("o_overrun before the extra write", o_overrun, '0);
    @(posedge i_clk);
    #1;
    i_wr         = 4'b0100;  // one write too many that the queue drops
    i_wr_data[2] = expected_word(2, wr_seq[2]);
    write_cycle('0);
    check_value("o_overrun after the extra write", o_overrun, 4'b0100);
    ack_en = 1'b1;
    wait_transfers(base + 17);
    n_ch2 = 0;
    for (int i = 0; i < 17; i++) begin
      if (ch_log[base+i] == 2) begin
        n_ch2++;
      end
    end
    check_value("words drained from channel 2", n_ch2, 16);
    check_value("channel 2 sequence after drain", exp_seq[2], wr_seq[2]);
    wait_idle();
    check_value("o_overrun after drain", o_overrun, 4'b0100);
    check_value("o_full after drain", o_full, '0);

    // random mixed traffic
    for (int i = 0; i < RAND_CYCLES; i++) begin
      rnd = $random(seed);
      write_cycle(rnd[N_CH-1:0]);
    end
    write_cycle('0);
    wait_transfers(total_written());
    wait_idle();
    for (int c = 0; c < N_CH; c++) begin
      if (exp_seq[c] != wr_seq[c]) begin
        $display("channel %0d delivered %0d of %0d words", c, exp_seq[c], wr_seq[c]);
        n_other++;
      end
    end
    check_value("o_underrun at end", o_underrun, '0);
    check_value("o_overrun at end", o_overrun, 4'b0100);
    check_value("o_empty at end", o_empty, {N_CH{1'b1}});
    end_run();
  end

endmodule

/* bench/merge_asserts.sv */
module merge_asserts #(
  parameter int DATA_W = merge_pkg::DATA_W_DEF
) (
  input logic                  i_clk,
  input logic                  i_rst_n,
  input logic                  i_req,
  input logic                  i_ack,
  input logic [DATA_W-1:0]     i_data,
  input merge_pkg::ch_idx_t    i_ch,
  input logic                  i_full,
  input logic                  i_empty
);

  timeunit 1ns;
  timeprecision 100ps;

  // payload frozen for the whole request phase
  a_stable_payload: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_req && $past(i_req)) |-> ($stable(i_data) && $stable(i_ch))
  ) else $error("o_data or o_ch changed while o_req was high");

  a_req_after_ack_low: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_req) |-> !$past(i_ack)   // ack of the last transfer must be gone
  ) else $error("o_req rose while i_ack was high");

  // a count can not be zero and full at once
  a_full_empty: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    !(i_full && i_empty)
  ) else $error("queue reports full and empty together");

endmodule

bind bus_req_ack merge_asserts #(
  .DATA_W (DATA_W)
) u_bus_asserts (
  .i_clk   (i_clk),
  .i_rst_n (i_rst_n),
  .i_req   (o_req),
  .i_ack   (i_ack),
  .i_data  (o_data),
  .i_ch    (o_ch),
  .i_full  (1'b0),
  .i_empty (1'b1)
);

bind srl_queue merge_asserts #(
  .DATA_W (DATA_W)
) u_queue_asserts (
  .i_clk   (i_clk),
  .i_rst_n (i_rst_n),
  .i_req   (1'b0),
  .i_ack   (1'b0),
  .i_data  (o_head),
  .i_ch    ('0),
  .i_full  (o_full),
  .i_empty (o_empty)
);

/* design/merge_top.sv */
module merge_top #(
  parameter int DATA_W     = merge_pkg::DATA_W_DEF,
  parameter int DEPTH_LOG2 = merge_pkg::DEPTH_LOG2_DEF,
  parameter int N_CH       = merge_pkg::N_CH_DEF
) (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic [N_CH-1:0]              i_wr,
  input  logic [N_CH-1:0][DATA_W-1:0]  i_wr_data,
  input  logic                         i_ack,
  output logic [N_CH-1:0]              o_full,
  output logic [N_CH-1:0]              o_empty,
  output logic [N_CH-1:0]              o_overrun,
  output logic [N_CH-1:0]              o_underrun,
  output logic                         o_req,
  output logic [DATA_W-1:0]            o_data,
  output merge_pkg::ch_idx_t           o_ch
);

  import merge_pkg::*;

  logic [N_CH-1:0][DATA_W-1:0] heads;     // head word of each queue
  logic [N_CH-1:0]             q_req;     // non-empty queues
  logic [N_CH-1:0]             pop;
  logic [DATA_W-1:0]           head_sel;
  logic                        gnt_valid;
  ch_idx_t                     gnt_ch;
  logic                        take;

  assign q_req    = ~o_empty;
  assign head_sel = heads[gnt_ch];  // granted queue feeds the output stage

  for (genvar g = 0; g < N_CH; g++) begin : g_ch
    // take pops only the queue that holds the grant
    assign pop[g] = take && (gnt_ch == ch_idx_t'(g));

    srl_queue #(
      .DATA_W     (DATA_W),
      .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_queue (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_wr       (i_wr[g]),
      .i_wr_data  (i_wr_data[g]),
      .i_pop      (pop[g]),
      .o_head     (heads[g]),
      .o_full     (o_full[g]),
      .o_empty    (o_empty[g]),
      .o_overrun  (o_overrun[g]),
      .o_underrun (o_underrun[g])
    );
  end

  rr_arbiter #(
    .N_CH (N_CH)
  ) u_arb (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req       (q_req),
    .i_take      (take),
    .o_gnt_valid (gnt_valid),
    .o_gnt_ch    (gnt_ch)
  );

  bus_req_ack #(
    .DATA_W (DATA_W)
  ) u_out (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_gnt_valid (gnt_valid),
    .i_gnt_ch    (gnt_ch),
    .i_head_data (head_sel),
    .i_ack       (i_ack),
    .o_take      (take),
    .o_req       (o_req),
    .o_data      (o_data),
    .o_ch        (o_ch)
  );

endmodule

/* design/bus_req_ack.sv */
module bus_req_ack #(
  parameter int DATA_W = merge_pkg::DATA_W_DEF
) (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_gnt_valid,
  input  merge_pkg::ch_idx_t i_gnt_ch,
  input  logic [DATA_W-1:0]  i_head_data,   // head of the granted queue
  input  logic               i_ack,
  output logic               o_take,        // one-cycle pop of the granted queue
  output logic               o_req,
  output logic [DATA_W-1:0]  o_data,
  output merge_pkg::ch_idx_t o_ch
);

  import merge_pkg::*;

  out_state_t state;
  out_state_t nxt_state;

  // take is the single cycle in LOAD, word and pop happen at the same edge
  assign o_take = (state == OUT_LOAD) && i_gnt_valid;

  // request is decoded from the state register, no extra flop
  assign o_req = (state == OUT_REQ);

  // next state logic
  always_comb begin
    nxt_state = state;
    case (state)
      OUT_IDLE: begin
        if (i_gnt_valid) begin
          nxt_state = OUT_LOAD;
        end
      end
      OUT_LOAD: begin
        // grant should still be there, fall back to idle if not
        nxt_state = i_gnt_valid ? OUT_REQ : OUT_IDLE;
      end
      OUT_REQ: begin
        if (i_ack) begin
          nxt_state = OUT_DROP;  // release req at this edge
        end
      end
      OUT_DROP: begin
        if (!i_ack) begin
          nxt_state = OUT_IDLE;  // consumer finished the four phases
        end
      end
      default: nxt_state = OUT_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= OUT_IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  // payload, loaded once per transfer and held through REQ and DROP
  always_ff @(posedge i_clk) begin
    if (o_take) begin
      o_data <= i_head_data;
      o_ch   <= i_gnt_ch;
    end
  end

endmodule

/* design/rr_arbiter.sv */
module rr_arbiter #(
  parameter int N_CH = merge_pkg::N_CH_DEF
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic [N_CH-1:0]   i_req,       // one bit per non-empty queue
  input  logic              i_take,      // output stage accepted the grant
  output logic              o_gnt_valid,
  output merge_pkg::ch_idx_t o_gnt_ch
);

  import merge_pkg::*;

  // channel served most recently, the scan starts just after it
  ch_idx_t last_ch;

  // rotating priority scan, purely combinational
  always_comb begin
    int idx;
    o_gnt_valid = 1'b0;
    o_gnt_ch    = '0;
    idx         = 0;
    for (int off = 1; off <= N_CH; off++) begin
      idx = (int'(last_ch) + off) % N_CH;
      if (!o_gnt_valid && i_req[idx]) begin  // first hit wins
        o_gnt_valid = 1'b1;
        o_gnt_ch    = ch_idx_t'(idx);
      end
    end
  end

  // the highest index after reset puts channel 0 first in line
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      last_ch <= ch_idx_t'(N_CH - 1);
    end else if (i_take) begin
      last_ch <= o_gnt_ch;  // remember who was served
    end
  end

  // requests only drop through a pop, and a pop only follows i_take,
  // so the grant cannot disappear between acceptance and take

endmodule

/* design/srl_queue.sv */
module srl_queue #(
  parameter int DATA_W     = merge_pkg::DATA_W_DEF,
  parameter int DEPTH_LOG2 = merge_pkg::DEPTH_LOG2_DEF
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_wr,
  input  logic [DATA_W-1:0] i_wr_data,
  input  logic              i_pop,
  output logic [DATA_W-1:0] o_head,
  output logic              o_full,
  output logic              o_empty,
  output logic              o_overrun,
  output logic              o_underrun
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  // shift register storage, index 0 holds the newest word
  logic [DEPTH-1:0][DATA_W-1:0] sr;

  // occupancy, one bit wider than the address so that DEPTH fits
  logic [DEPTH_LOG2:0]   cnt;
  logic [DEPTH_LOG2:0]   cnt_m1;
  logic [DEPTH_LOG2-1:0] head_addr;

  logic wr_ok;
  logic pop_ok;

  // a pop only counts when there is something to pop
  assign pop_ok = i_pop & ~o_empty;

  // write goes in unless full, but a pop in the same cycle frees the slot
  assign wr_ok = i_wr & (~o_full | pop_ok);

  // flags come straight from the count
  assign o_empty = (cnt == '0);
  assign o_full  = cnt[DEPTH_LOG2];   // only set when cnt == DEPTH

  // oldest word sits at cnt-1, after cnt shifts
  assign cnt_m1    = cnt - 1'b1;
  assign head_addr = cnt_m1[DEPTH_LOG2-1:0];

  // combinational read of the head, valid in the same cycle
  assign o_head = sr[head_addr];

  // storage shifts on every accepted write
  always_ff @(posedge i_clk) begin
    if (wr_ok) begin
      sr <= {sr[DEPTH-2:0], i_wr_data};
    end
  end

  // occupancy counter
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      cnt <= '0;
    end else begin
      case ({wr_ok, pop_ok})
        2'b10:   cnt <= cnt + 1'b1;  // write only
        2'b01:   cnt <= cnt - 1'b1;  // pop only
        default: cnt <= cnt;         // both or neither, count unchanged
      endcase
    end
  end

  // sticky overrun, a dropped write stays visible until reset
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_overrun <= 1'b0;
    end else if (i_wr && !wr_ok) begin
      o_overrun <= 1'b1;
    end
  end

  // sticky underrun on a pop of an empty queue
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_underrun <= 1'b0;
    end else if (i_pop && o_empty) begin
      o_underrun <= 1'b1;
    end
  end

  // note: on a full queue with write and pop together, the popped word
  // is shifted out at index DEPTH-1 as the new word enters at index 0,
  // so the count and the head address stay where they were

endmodule

/* design/merge_pkg.sv */
package merge_pkg;

  // default word width of every queue and of the output bus
  localparam int DATA_W_DEF = 32;

  // default queue address width, 16 entries per channel
  localparam int DEPTH_LOG2_DEF = 4;

  // channels instantiated by default
  localparam int N_CH_DEF = 4;

  // upper bound on channels, sizes the channel index
  localparam int MAX_CH = 8;
  localparam int CH_W = $clog2(MAX_CH);

  // channel number as carried on the grant and on the output bus
  typedef logic [CH_W-1:0] ch_idx_t;

  // output stage FSM
  //   OUT_IDLE  waiting for a grant from the arbiter
  //   OUT_LOAD  latch granted word and channel, pop its queue
  //   OUT_REQ   o_req high until the consumer acks
  //   OUT_DROP  o_req low, waiting for ack to fall
  typedef enum logic [1:0] {
    OUT_IDLE = 2'd0,
    OUT_LOAD = 2'd1,
    OUT_REQ  = 2'd2,
    OUT_DROP = 2'd3
  } out_state_t;

endpackage
